/* Bender.yml */
package:
  name: core_frontend

sources:
  - design/l15_core_pkg.sv
  - design/fetch_stage.sv
  - design/mem_port.sv
  - design/l15_arbiter.sv
  - design/core_frontend.sv
  - target: test
    files:
      - dv/tb_core_frontend.sv

/* design/core_frontend.sv */
`timescale 1ns/1ps

module core_frontend import l15_core_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,
	input  logic        redirect,
	input  logic [31:0] target,
	input  logic        mem_cmd_val,
	input  mem_cmd_t    mem_cmd,
	input  logic        header_ack,
	input  logic        resp_val,
	input  l15_resp_t   l15_resp,
	output logic        instr_valid,
	output logic [31:0] pc_out,
	output logic [31:0] instr,
	output logic        mem_busy,
	output logic        mem_done,
	output logic [31:0] mem_rdata,
	output l15_req_t    l15_req,
	output logic        req_val,
	output logic        resp_ack
);

	l15_req_t fetch_req;
	l15_req_t mem_req;
	logic     fetch_val;
	logic     fetch_taken;
	logic     mem_val;
	logic     mem_taken;
	logic     fetch_resp_val;
	logic     mem_resp_val;
	logic     int_val;

	fetch_stage i_fetch_stage (
		.clk, .nrst, .stall, .redirect, .target,
		.fetch_taken, .fetch_resp_val, .l15_resp, .int_val,
		.fetch_val, .fetch_req, .instr_valid, .pc_out, .instr
	);

	mem_port i_mem_port (
		.clk, .nrst, .mem_cmd_val, .mem_cmd,
		.mem_taken, .mem_resp_val, .l15_resp,
		.mem_val, .mem_req, .mem_busy, .mem_done, .mem_rdata
	);

	// single shared l1.5 port
	l15_arbiter i_l15_arbiter (
		.clk, .nrst, .fetch_val, .fetch_req, .mem_val, .mem_req,
		.header_ack, .resp_val, .l15_resp_in (l15_resp),
		.fetch_taken, .mem_taken, .req_val, .l15_req, .resp_ack,
		.fetch_resp_val, .mem_resp_val, .int_val
	);

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import l15_core_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,
	input  logic        redirect,
	input  logic [31:0] target,
	input  logic        fetch_taken,
	input  logic        fetch_resp_val,
	input  l15_resp_t   l15_resp,
	input  logic        int_val,
	output logic        fetch_val,
	output l15_req_t    fetch_req,
	output logic        instr_valid,
	output logic [31:0] pc_out,
	output logic [31:0] instr
);

	typedef enum logic {S_REQ, S_WAIT} state_e;

	state_e      state_q;
	logic        wake_q;
	logic        req_hold_q;   // request shown but not yet taken
	logic        redir_pend_q; // in-flight response must be dropped
	logic [31:0] redir_pc_q;
	logic [31:0] pc_q;
	logic [31:0] word;
	logic        deliver;

	// once shown, a request stays up regardless of stall
	assign fetch_val = (state_q == S_REQ) && wake_q && (req_hold_q || !stall);

	always_comb
	begin
		fetch_req         = '0;
		fetch_req.rqtype  = LOAD_RQ;
		fetch_req.size    = SIZE_WORD;
		fetch_req.address = pc_q;
	end

	assign word    = bswap32(pick_word(l15_resp, pc_q[3:2]));
	assign deliver = fetch_resp_val && !redir_pend_q && !redirect;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			wake_q <= 1'b0;
		else if (int_val)
			wake_q <= 1'b1; // interrupt return wakes the core
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state_q    <= S_REQ;
			req_hold_q <= 1'b0;
		end
		else
		begin
			req_hold_q <= fetch_val && !fetch_taken;
			case (state_q)
				S_REQ:
					if (fetch_taken)
						state_q <= S_WAIT;
				S_WAIT:
					if (fetch_resp_val)
						state_q <= S_REQ;
				default:
					state_q <= S_REQ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (redirect)
			redir_pc_q <= target;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc_q         <= BOOT_PC;
			redir_pend_q <= 1'b0;
		end
		else if (redirect && (fetch_resp_val || (state_q == S_REQ && !fetch_val)))
		begin
			// nothing left in flight
			pc_q         <= target;
			redir_pend_q <= 1'b0;
		end
		else if (redirect)
			redir_pend_q <= 1'b1; // wait for the stale response
		else if (fetch_resp_val)
		begin
			if (redir_pend_q)
				pc_q <= redir_pc_q;
			else
				pc_q <= pc_q + 32'd4;
			redir_pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			instr_valid <= 1'b0;
			pc_out      <= '0;
			instr       <= NOP_INSTR;
		end
		else
		begin
			instr_valid <= deliver;
			if (redirect)
				instr <= NOP_INSTR; // bubble until the new path arrives
			else if (deliver)
			begin
				instr  <= word;
				pc_out <= pc_q;
			end
		end
	end

	a_no_fetch_asleep: assert property (@(posedge clk) disable iff (!nrst)
		fetch_val |-> wake_q);

	// the l1.5 handshake needs a stable address until header_ack
	a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
		fetch_val && !fetch_taken |=> fetch_val && $stable(fetch_req.address));

endmodule

/* design/l15_arbiter.sv */
`timescale 1ns/1ps

module l15_arbiter import l15_core_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  logic      fetch_val,
	input  l15_req_t  fetch_req,
	input  logic      mem_val,
	input  l15_req_t  mem_req,
	input  logic      header_ack,
	input  logic      resp_val,
	input  l15_resp_t l15_resp_in,
	output logic      fetch_taken,
	output logic      mem_taken,
	output logic      req_val,
	output l15_req_t  l15_req,
	output logic      resp_ack,
	output logic      fetch_resp_val,
	output logic      mem_resp_val,
	output logic      int_val
);

	// present means shown on the port but not yet acked
	typedef enum logic [1:0] {PH_IDLE, PH_PRESENT, PH_BUSY} phase_e;

	typedef struct packed {
		phase_e phase;
		logic   mem; // owner is the memory port
	} owner_t;

	owner_t own_q;
	owner_t own_d;
	logic   grant_mem;
	logic   grant_fetch;
	logic   to_owner;

	always_comb
	begin
		grant_mem   = 1'b0;
		grant_fetch = 1'b0;
		case (own_q.phase)
			PH_IDLE:
			begin
				grant_mem   = mem_val;               // memory first
				grant_fetch = fetch_val && !mem_val;
			end
			PH_PRESENT:
			begin
				// keep the request already on the port
				grant_mem   = own_q.mem && mem_val;
				grant_fetch = !own_q.mem && fetch_val;
			end
			default: ;
		endcase
	end

	assign req_val     = grant_mem || grant_fetch;
	assign l15_req     = grant_mem ? mem_req : fetch_req;
	assign mem_taken   = grant_mem && header_ack;
	assign fetch_taken = grant_fetch && header_ack;

	always_comb
	begin
		to_owner = 1'b0;
		int_val  = 1'b0;
		if (resp_val)
		begin
			case (l15_resp_in.returntype)
				LOAD_RET, IFILL_RET, ST_ACK: to_owner = (own_q.phase == PH_BUSY);
				INT_RET: int_val = 1'b1;
				INV_RET: ; // no l1 in the core
				default: ;
			endcase
		end
	end

	assign resp_ack       = resp_val; // every response is taken at once
	assign fetch_resp_val = to_owner && !own_q.mem;
	assign mem_resp_val   = to_owner && own_q.mem;

	always_comb
	begin
		own_d = own_q;
		if (own_q.phase == PH_BUSY)
		begin
			if (to_owner)
				own_d.phase = PH_IDLE;
		end
		else if (req_val)
		begin
			own_d.phase = header_ack ? PH_BUSY : PH_PRESENT;
			own_d.mem   = grant_mem;
		end
		else
			own_d.phase = PH_IDLE;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			own_q <= '{phase: PH_IDLE, mem: 1'b0};
		else
			own_q <= own_d;
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!nrst)
		!(fetch_taken && mem_taken));

endmodule

/* design/l15_core_pkg.sv */
package l15_core_pkg;

	// l1.5 request types
	localparam logic [4:0] LOAD_RQ  = 5'b00000;
	localparam logic [4:0] STORE_RQ = 5'b00001;

	// l1.5 return types
	localparam logic [3:0] LOAD_RET  = 4'b0000;
	localparam logic [3:0] IFILL_RET = 4'b0001;
	localparam logic [3:0] INV_RET   = 4'b0011;
	localparam logic [3:0] ST_ACK    = 4'b0100;
	localparam logic [3:0] INT_RET   = 4'b0111;

	localparam logic [2:0] SIZE_WORD = 3'b010; // 4 byte access

	localparam logic [31:0] BOOT_PC   = 32'h4000_0000;
	localparam logic [31:0] NOP_INSTR = 32'h0000_0033; // add x0, x0, x0

	// core to l1.5
	typedef struct packed {
		logic [4:0]  rqtype;
		logic [2:0]  size;
		logic [31:0] address;
		logic [63:0] data;
	} l15_req_t;

	// l1.5 to core, one 128-bit line in two halves
	typedef struct packed {
		logic [3:0]  returntype;
		logic [63:0] data_0;
		logic [63:0] data_1;
	} l15_resp_t;

	// single load/store from the memory stage
	typedef struct packed {
		logic        store;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_cmd_t;

	// word of the returned line picked by address bits 3:2
	function automatic logic [31:0] pick_word(input l15_resp_t resp, input logic [1:0] lane);
		logic [31:0] w;
		case (lane)
			2'd0: w = resp.data_0[63:32];
			2'd1: w = resp.data_0[31:0];
			2'd2: w = resp.data_1[63:32];
			default: w = resp.data_1[31:0];
		endcase
		return w;
	endfunction

	// line is big-endian, core is little-endian
	function automatic logic [31:0] bswap32(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

/* design/mem_port.sv */
`timescale 1ns/1ps

module mem_port import l15_core_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        mem_cmd_val,
	input  mem_cmd_t    mem_cmd,
	input  logic        mem_taken,
	input  logic        mem_resp_val,
	input  l15_resp_t   l15_resp,
	output logic        mem_val,
	output l15_req_t    mem_req,
	output logic        mem_busy,
	output logic        mem_done,
	output logic [31:0] mem_rdata
);

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_e;

	state_e      state_q;
	mem_cmd_t    cmd_q;
	logic [31:0] st_word;
	logic [63:0] st_data;

	assign mem_val  = (state_q == S_REQ);
	assign mem_busy = (state_q != S_IDLE);

	// store word goes big-endian into the half picked by addr[2]
	assign st_word = bswap32(cmd_q.wdata);
	assign st_data = cmd_q.addr[2] ? {32'h0, st_word} : {st_word, 32'h0};

	always_comb
	begin
		mem_req         = '0;
		mem_req.rqtype  = cmd_q.store ? STORE_RQ : LOAD_RQ;
		mem_req.size    = SIZE_WORD;
		mem_req.address = cmd_q.addr;
		mem_req.data    = cmd_q.store ? st_data : 64'h0;
	end

	always_ff @(posedge clk)
	begin
		if (mem_cmd_val && !mem_busy)
			cmd_q <= mem_cmd;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			state_q <= S_IDLE;
		else
		begin
			case (state_q)
				S_IDLE:
					if (mem_cmd_val)
						state_q <= S_REQ;
				S_REQ:
					if (mem_taken)
						state_q <= S_WAIT;
				S_WAIT:
					if (mem_resp_val)
						state_q <= S_IDLE;
				default:
					state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			mem_done <= 1'b0;
		else
			mem_done <= mem_resp_val; // one cycle after the response
	end

	// load data held until the next load completes
	always_ff @(posedge clk)
	begin
		if (mem_resp_val && !cmd_q.store)
			mem_rdata <= bswap32(pick_word(l15_resp, cmd_q.addr[3:2]));
	end

	a_no_cmd_busy: assert property (@(posedge clk) disable iff (!nrst)
		mem_cmd_val |-> !mem_busy);

endmodule

/* dv/tb_core_frontend.sv */
`timescale 1ns/1ps

module tb_core_frontend import l15_core_pkg::*;
();

	localparam int          N_TESTS   = 6;
	localparam logic [31:0] MODEL_KEY = 32'h5a5a_0000;

	logic        clk, nrst, stall, redirect, mem_cmd_val, header_ack, resp_val;
	logic        instr_valid, mem_busy, mem_done, req_val, resp_ack;
	logic [31:0] target, pc_out, instr, mem_rdata;
	mem_cmd_t    mem_cmd;
	l15_resp_t   l15_resp;
	l15_req_t    l15_req;

	logic [31:0] lfsr = 32'ha567;
	logic [31:0] store_mem [logic [31:0]]; // words written by stores
	l15_req_t    taken_q [$];              // every request the model accepted
	logic        busy;                     // model holds a taken request
	logic        inv_pending;              // next answer is preceded by INV_RET
	logic [31:0] exp_pc;
	logic [31:0] last_pc;
	logic [3:0]  lanes_seen;
	int          n_instr;
	int          n_err;

	core_frontend i_core_frontend (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [3:0] rand_bits(input int n);
		logic [3:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[2:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] model_word(input logic [31:0] a);
		if (store_mem.exists(a))
			return store_mem[a];
		return a ^ MODEL_KEY;
	endfunction

	// byte k of the line sits at bits 127-8k
	// memory words themselves are little-endian
	function automatic logic [127:0] model_line(input logic [31:0] a);
		logic [127:0] line;
		logic [31:0]  w;
		for (int k = 0; k < 16; k++)
		begin
			w = model_word({a[31:4], 4'h0} + 32'(4 * (k / 4)));
			line[127 - 8 * k -: 8] = w[8 * (k % 4) +: 8];
		end
		return line;
	endfunction

	// store data from the half picked by address bit 2 in memory byte order
	function automatic logic [31:0] store_word(input l15_req_t req);
		logic [31:0] half;
		logic [31:0] w;
		half = req.address[2] ? req.data[31:0] : req.data[63:32];
		for (int k = 0; k < 4; k++)
			w[8 * k +: 8] = half[31 - 8 * k -: 8];
		return w;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got, exp);
		$display("Fail %s got %h expected %h", name, got, exp);
		n_err++;
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		n_err++;
	endtask

	// one response cycle with resp_ack expected in the same cycle
	task automatic send_resp(input logic [3:0] rtype, input logic [127:0] line);
		resp_val = 1'b1;
		l15_resp = '{returntype: rtype, data_0: line[127:64], data_1: line[63:0]};
		@(posedge clk);
		if (resp_ack !== 1'b1)
			report_mismatch("resp_ack", 32'(resp_ack), 32'h1);
		@(negedge clk);
		resp_val = 1'b0;
	endtask

	// l1.5 model
	initial
	begin : responder
		l15_req_t req;
		int       delay;
		header_ack  = 1'b0;
		resp_val    = 1'b0;
		l15_resp    = '0;
		busy        = 1'b0;
		inv_pending = 1'b0;
		@(posedge nrst);
		@(negedge clk);
		forever
		begin
			repeat (rand_bits(2)) @(negedge clk); // header_ack held low 0-3 cycles
			header_ack = 1'b1;
			@(posedge clk);
			while (!req_val)
				@(posedge clk);
			req = l15_req;
			taken_q.push_back(req);
			busy = 1'b1;
			@(negedge clk);
			header_ack = 1'b0;
			delay = rand_bits(2);
			if (inv_pending)
			begin
				send_resp(INV_RET, {4{32'hdead_beef}}); // dropped by the core
				inv_pending = 1'b0;
				if (delay != 0)
					delay--;
			end
			repeat (delay) @(negedge clk); // answer 1-4 cycles later
			if (req.rqtype == STORE_RQ)
			begin
				store_mem[{req.address[31:2], 2'b00}] = store_word(req);
				send_resp(ST_ACK, '0);
			end
			else
				send_resp(LOAD_RET, model_line(req.address));
			busy = 1'b0;
		end
	end

	// delivered stream follows pc order and restarts at a redirect target
	always @(posedge clk)
	begin
		if (nrst && instr_valid)
		begin
			if (pc_out !== exp_pc)
				report_mismatch("pc_out", pc_out, exp_pc);
			if (instr !== model_word(pc_out))
				report_mismatch("instr", instr, model_word(pc_out));
			lanes_seen[pc_out[3:2]] = 1'b1;
			last_pc = pc_out;
			exp_pc  = pc_out + 32'd4;
			n_instr++;
		end
		if (nrst && redirect)
			exp_pc = target;
	end

	task automatic wait_instrs(input int n);
		int goal;
		int cycles;
		goal   = n_instr + n;
		cycles = 0;
		while (n_instr < goal && cycles < 100 * n)
		begin
			@(negedge clk);
			cycles++;
		end
		if (n_instr < goal)
			report_problem("expected instruction was not delivered in time");
	endtask

	task automatic wait_mem_done();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (mem_done !== 1'b1 && cycles < 200)
		begin
			@(posedge clk);
			cycles++;
		end
		if (mem_done !== 1'b1)
			report_problem("mem_done did not arrive in time");
		@(negedge clk);
	endtask

	task automatic wait_idle();
		@(posedge clk);
		while (busy || req_val)
			@(posedge clk);
		@(negedge clk);
	endtask

	task automatic test_wakeup();
		repeat (50)
		begin
			@(posedge clk);
			if (req_val !== 1'b0)
				report_mismatch("req_val", 32'(req_val), 32'h0);
		end
		if ({resp_ack, instr_valid, mem_busy, mem_done} !== 4'h0)
			report_mismatch("resp_ack/instr_valid/mem_busy/mem_done",
				32'({resp_ack, instr_valid, mem_busy, mem_done}), 32'h0);
		if (instr !== NOP_INSTR)
			report_mismatch("instr", instr, NOP_INSTR);
		@(negedge clk);
		send_resp(INT_RET, '0);
		wait_instrs(1);
		if (taken_q.size() == 0)
			report_problem("no request was issued after wake-up");
		else if (taken_q[0].address !== BOOT_PC)
			report_mismatch("l15_req.address", taken_q[0].address, BOOT_PC);
	endtask

	task automatic test_sequential();
		lanes_seen = '0;
		wait_instrs(20);
		if (lanes_seen !== 4'hf)
			report_mismatch("lanes_seen", 32'(lanes_seen), 32'hf);
	endtask

	task automatic test_redirect();
		wait (!busy);
		wait (busy); // a fetch is now in flight
		@(negedge clk);
		redirect = 1'b1;
		target   = 32'h4000_1008;
		@(negedge clk);
		redirect = 1'b0;
		@(posedge clk);
		if (instr !== NOP_INSTR)
			report_mismatch("instr", instr, NOP_INSTR);
		wait_instrs(1);
		if (last_pc !== 32'h4000_1008)
			report_mismatch("pc_out", last_pc, 32'h4000_1008);
		stall = 1'b1;
		wait_idle();
		redirect = 1'b1;
		target   = 32'h4000_2004;
		@(negedge clk);
		redirect = 1'b0;
		stall    = 1'b0;
		wait_instrs(1);
		if (last_pc !== 32'h4000_2004)
			report_mismatch("pc_out", last_pc, 32'h4000_2004);
	endtask

	task automatic test_stall();
		int taken_before;
		int instr_before;
		stall = 1'b1;
		wait_idle();
		taken_before = taken_q.size();
		instr_before = n_instr;
		repeat (30)
		begin
			@(posedge clk);
			if (req_val !== 1'b0)
				report_mismatch("req_val", 32'(req_val), 32'h0);
		end
		if (taken_q.size() != taken_before || n_instr != instr_before)
			report_problem("fetch went on while stall was high");
		@(negedge clk);
		stall = 1'b0;
		wait_instrs(3);
	endtask

	task automatic test_store_load();
		logic [31:0] addr;
		logic [31:0] data;
		int          idx;
		for (int i = 0; i < 2; i++)
		begin
			addr = 32'h8000_0104 + 32'(i) * 32'h104;
			data = addr ^ 32'hc001_d00d;
			wait (!busy);
			wait (busy); // store arrives while a fetch is outstanding
			@(negedge clk);
			idx         = taken_q.size();
			mem_cmd_val = 1'b1;
			mem_cmd     = '{store: 1'b1, addr: addr, wdata: data};
			@(negedge clk);
			mem_cmd_val = 1'b0;
			if (mem_busy !== 1'b1)
				report_mismatch("mem_busy", 32'(mem_busy), 32'h1);
			wait_mem_done();
			if (taken_q.size() <= idx)
				report_problem("store request was never taken");
			else
			begin
				if (taken_q[idx].rqtype !== STORE_RQ)
					report_mismatch("l15_req.rqtype", 32'(taken_q[idx].rqtype),
						32'(STORE_RQ));
				if (taken_q[idx].address !== addr)
					report_mismatch("l15_req.address", taken_q[idx].address, addr);
			end
			mem_cmd_val = 1'b1;
			mem_cmd     = '{store: 1'b0, addr: addr, wdata: 32'h0};
			@(negedge clk);
			mem_cmd_val = 1'b0;
			wait_mem_done();
			if (mem_rdata !== data)
				report_mismatch("mem_rdata", mem_rdata, data);
		end
		wait_instrs(2);
	endtask

	task automatic test_inv_ret();
		logic [31:0] pc_hold;
		int          cycles;
		@(posedge clk);
		inv_pending = 1'b1; // lands while the next fetch is outstanding
		cycles      = 0;
		@(posedge clk);
		while (!(resp_val && l15_resp.returntype == INV_RET) && cycles < 200)
		begin
			@(posedge clk);
			cycles++;
		end
		if (!(resp_val && l15_resp.returntype == INV_RET))
			report_problem("INV_RET response was never sent");
		else
		begin
			pc_hold = pc_out;
			@(posedge clk);
			if (instr_valid !== 1'b0 || mem_done !== 1'b0)
				report_problem("INV_RET response produced a completion");
			if (pc_out !== pc_hold)
				report_mismatch("pc_out", pc_out, pc_hold);
		end
		@(negedge clk);
		wait_instrs(2);
	endtask

	initial
	begin
		nrst        = 1'b0;
		stall       = 1'b0;
		redirect    = 1'b0;
		target      = '0;
		mem_cmd_val = 1'b0;
		mem_cmd     = '0;
		exp_pc      = BOOT_PC;
		last_pc     = '0;
		lanes_seen  = '0;
		n_instr     = 0;
		n_err       = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		test_wakeup();
		test_sequential();
		test_redirect();
		test_stall();
		test_store_load();
		test_inv_ret();
		$display("tests %0d, instructions %0d, errors %0d", N_TESTS, n_instr, n_err);
		if (n_err == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		#(N_TESTS * 2000);
		$display("watchdog expired before the tests completed");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* sources.f */
design/l15_core_pkg.sv
design/fetch_stage.sv
design/mem_port.sv
design/l15_arbiter.sv
design/core_frontend.sv
dv/tb_core_frontend.sv
